// File: design/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// ------------------------------
// core widths
// ------------------------------

// data and address width
`define XLEN 32

// register index width
`define REG_ADDR_W 5

// architectural registers, x0 included
`define REG_COUNT 32

// ------------------------------
// program counter
// ------------------------------

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

// byte step of sequential fetch
`define PC_STEP 32'd4

`endif

// File: design/rv_pkg.sv
`default_nettype none

`include "rv_defines.svh"

package rv_pkg;

  // ------------------------------
  // encodings
  // ------------------------------

  // major opcodes, rv32i values
  typedef enum logic [6:0] {
    lui    = 7'b0110111,
    auipc  = 7'b0010111,
    jal    = 7'b1101111,
    jalr   = 7'b1100111,
    branch = 7'b1100011,
    op_imm = 7'b0010011,
    op     = 7'b0110011,
    system = 7'b1110011
  } opcode_e;

  // alu functions, pass_imm for lui and add_pc for auipc
  typedef enum logic [3:0] {
    add, sub, sll, slt, sltu, xor_op, srl, sra, or_op, and_op, pass_imm, add_pc
  } alu_op_e;

  // branch conditions, same as funct3
  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_cond_e;

  // ------------------------------
  // pipeline words
  // ------------------------------

  // decode to execute register
  typedef struct packed {
    logic                   valid;
    opcode_e                opcode;
    alu_op_e                alu_op;
    branch_cond_e           branch_cond;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       rs1_val;
    logic [`XLEN-1:0]       rs2_val;
    logic [`XLEN-1:0]       imm;
    logic [`XLEN-1:0]       pc;
    // second alu operand is imm, not rs2
    logic                   use_imm;
  } decoded_t;

  // register writeback
  typedef struct packed {
    logic                   valid;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
  } wb_t;

  // pc redirect for taken branches and jumps
  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] target;
  } redirect_t;

endpackage

`default_nettype wire

// File: design/register_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defines.svh"

module register_file (
  input  logic                   clock,
  input  logic                   rst_n,
  input  logic [`REG_ADDR_W-1:0] rs1_addr,
  input  logic [`REG_ADDR_W-1:0] rs2_addr,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data,
  input  rv_pkg::wb_t            wb
);

  // x1..x31 only, x0 is not stored
  logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

  // one read port
  // x0 reads zero, a same-cycle write wins over the array
  function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
    logic [`XLEN-1:0] value;
    if (addr == '0) begin
      value = '0;
    end else if (wb.valid && (wb.rd == addr)) begin
      value = wb.data;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  // write through to the decoder in the same cycle
  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  // write at the edge ending the execute cycle
  // nothing lands while reset is held
  always_ff @(posedge clock) begin
    if (rst_n && wb.valid && (wb.rd != '0)) begin
      regs[wb.rd] <= wb.data;
    end
  end

endmodule

`default_nettype wire

// File: design/fetch_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defines.svh"

module fetch_decode import rv_pkg::*; (
  input  logic                   clock,
  input  logic                   rst_n,
  output logic [`XLEN-1:0]       imem_addr,
  input  logic [`XLEN-1:0]       imem_data,
  input  redirect_t              redirect,
  input  logic                   halted,
  output logic [`REG_ADDR_W-1:0] rs1_addr,
  output logic [`REG_ADDR_W-1:0] rs2_addr,
  input  logic [`XLEN-1:0]       rs1_data,
  input  logic [`XLEN-1:0]       rs2_data,
  output decoded_t               decoded
);

  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;
  logic [`XLEN-1:0] imm_b;
  logic [2:0]       funct3;
  // funct7 bit 5, picks sub and sra
  logic             alt;
  logic             halt_now;
  decoded_t         next_word;

  // funct3 to alu op
  // addi has no sub form, so sub_ok is low for op_imm
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt_bit,
                                       input logic sub_ok);
    alu_op_e sel;
    case (f3)
      3'b000:  sel = (alt_bit && sub_ok) ? sub : add;
      3'b001:  sel = sll;
      3'b010:  sel = slt;
      3'b011:  sel = sltu;
      3'b100:  sel = xor_op;
      3'b101:  sel = alt_bit ? sra : srl;
      3'b110:  sel = or_op;
      default: sel = and_op;
    endcase
    return sel;
  endfunction

  // ------------------------------
  // fetch
  // ------------------------------

  assign imem_addr = pc;

  // halt also covers the ecall now in execute,
  // since the halted flag is one cycle late
  assign halt_now = halted || (decoded.valid && (decoded.opcode == system));

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      pc <= `RESET_PC;
    end else if (halt_now) begin
      pc <= pc;
    end else if (redirect.valid) begin
      pc <= redirect.target;
    end else begin
      pc <= pc + `PC_STEP;
    end
  end

  // ------------------------------
  // decode
  // ------------------------------

  assign funct3   = imem_data[14:12];
  assign alt      = imem_data[30];
  assign rs1_addr = imem_data[19:15];
  assign rs2_addr = imem_data[24:20];

  // immediate formats
  assign imm_i = {{(`XLEN-12){imem_data[31]}}, imem_data[31:20]};
  assign imm_u = {imem_data[31:12], 12'b0};
  assign imm_j = {{(`XLEN-20){imem_data[31]}}, imem_data[19:12], imem_data[20],
                  imem_data[30:21], 1'b0};
  assign imm_b = {{(`XLEN-12){imem_data[31]}}, imem_data[7], imem_data[30:25],
                  imem_data[11:8], 1'b0};

  always_comb begin
    next_word             = '0;
    // fetched word dies on redirect or halt
    next_word.valid       = !halt_now && !redirect.valid;
    next_word.opcode      = opcode_e'(imem_data[6:0]);
    next_word.alu_op      = add;
    next_word.branch_cond = branch_cond_e'(funct3);
    next_word.rd          = imem_data[11:7];
    next_word.rs1_val     = rs1_data;
    next_word.rs2_val     = rs2_data;
    next_word.imm         = imm_i;
    next_word.pc          = pc;
    next_word.use_imm     = 1'b0;
    case (next_word.opcode)
      lui: begin
        next_word.imm     = imm_u;
        next_word.alu_op  = pass_imm;
        next_word.use_imm = 1'b1;
      end
      auipc: begin
        next_word.imm     = imm_u;
        next_word.alu_op  = add_pc;
        next_word.use_imm = 1'b1;
      end
      jal:    next_word.imm = imm_j;
      branch: next_word.imm = imm_b;
      // i-type offset, target built in the branch unit
      jalr, system: next_word.imm = imm_i;
      op_imm: begin
        // shamt sits in imm bits 4:0
        next_word.alu_op  = arith_op(funct3, alt, 1'b0);
        next_word.use_imm = 1'b1;
      end
      op: next_word.alu_op = arith_op(funct3, alt, 1'b1);
      // unknown opcode becomes a bubble
      default: next_word.valid = 1'b0;
    endcase
  end

  // stage two register, payload has no reset
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      decoded.valid <= 1'b0;
    end else begin
      decoded <= next_word;
    end
  end

endmodule

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defines.svh"

module alu import rv_pkg::*; (
  input  decoded_t         decoded,
  output logic [`XLEN-1:0] result
);

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [4:0]       shamt;
  logic             lt_signed;
  logic             lt_unsigned;

  // ------------------------------
  // operands
  // ------------------------------

  assign op_a = decoded.rs1_val;
  // immediate for op_imm, lui and auipc
  assign op_b = decoded.use_imm ? decoded.imm : decoded.rs2_val;
  // shifts look at five bits only
  assign shamt = op_b[4:0];

  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;

  // ------------------------------
  // function select
  // ------------------------------

  always_comb begin
    case (decoded.alu_op)
      add:      result = op_a + op_b;
      sub:      result = op_a - op_b;
      sll:      result = op_a << shamt;
      slt:      result = {{(`XLEN-1){1'b0}}, lt_signed};
      sltu:     result = {{(`XLEN-1){1'b0}}, lt_unsigned};
      xor_op:   result = op_a ^ op_b;
      srl:      result = op_a >> shamt;
      // arithmetic, sign bit fills from the left
      sra:      result = $signed(op_a) >>> shamt;
      or_op:    result = op_a | op_b;
      and_op:   result = op_a & op_b;
      // lui
      pass_imm: result = decoded.imm;
      // auipc
      add_pc:   result = decoded.pc + decoded.imm;
      default:  result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/branch_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defines.svh"

module branch_unit import rv_pkg::*; (
  input  decoded_t         decoded,
  output logic             taken,
  output logic [`XLEN-1:0] target,
  output logic [`XLEN-1:0] link
);

  logic [`XLEN-1:0] rs1_val;
  logic [`XLEN-1:0] rs2_val;
  logic             eq;
  logic             lt;
  logic             ltu;
  logic             cond_true;
  logic [`XLEN-1:0] jalr_sum;

  assign rs1_val = decoded.rs1_val;
  assign rs2_val = decoded.rs2_val;

  // comparator
  assign eq  = rs1_val == rs2_val;
  assign lt  = $signed(rs1_val) < $signed(rs2_val);
  assign ltu = rs1_val < rs2_val;

  always_comb begin
    case (decoded.branch_cond)
      beq:     cond_true = eq;
      bne:     cond_true = !eq;
      blt:     cond_true = lt;
      bge:     cond_true = !lt;
      bltu:    cond_true = ltu;
      bgeu:    cond_true = !ltu;
      // funct3 010 and 011 are not branches
      default: cond_true = 1'b0;
    endcase
  end

  // ------------------------------
  // target and taken
  // ------------------------------

  assign jalr_sum = rs1_val + decoded.imm;

  always_comb begin
    taken  = 1'b0;
    target = decoded.pc + decoded.imm;
    case (decoded.opcode)
      jal: taken = 1'b1;
      jalr: begin
        taken  = 1'b1;
        // bit 0 dropped
        target = {jalr_sum[`XLEN-1:1], 1'b0};
      end
      branch:  taken = cond_true;
      default: taken = 1'b0;
    endcase
  end

  // return address for jal and jalr
  assign link = decoded.pc + `PC_STEP;

endmodule

`default_nettype wire

// File: design/commit_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defines.svh"

module commit_unit import rv_pkg::*; (
  input  logic             clock,
  input  logic             rst_n,
  input  decoded_t         decoded,
  input  logic [`XLEN-1:0] alu_result,
  input  logic             taken,
  input  logic [`XLEN-1:0] target,
  input  logic [`XLEN-1:0] link,
  output wb_t              wb,
  output redirect_t        redirect,
  output logic             halted,
  output logic [`XLEN-1:0] instret
);

  logic writes_rd;
  logic is_jump;

  // ------------------------------
  // writeback
  // ------------------------------

  // opcodes that produce rd
  always_comb begin
    case (decoded.opcode)
      lui, auipc, jal, jalr, op_imm, op: writes_rd = 1'b1;
      default:                           writes_rd = 1'b0;
    endcase
  end

  assign is_jump = (decoded.opcode == jal) || (decoded.opcode == jalr);

  // x0 writes never leave the core
  assign wb.valid = decoded.valid && writes_rd && (decoded.rd != '0);
  assign wb.rd    = decoded.rd;
  assign wb.data  = is_jump ? link : alu_result;

  // redirect in the execute cycle, fetch drops its word
  assign redirect.valid  = decoded.valid && taken;
  assign redirect.target = target;

  // ------------------------------
  // status
  // ------------------------------

  // sticky halt on ecall/ebreak, counter sees every valid word
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      halted  <= 1'b0;
      instret <= '0;
    end else if (decoded.valid) begin
      instret <= instret + 1'b1;
      if (decoded.opcode == system) begin
        halted <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/rv_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defines.svh"

module rv_core import rv_pkg::*; (
  input  logic             clock,
  input  logic             rst_n,
  output logic [`XLEN-1:0] imem_addr,
  input  logic [`XLEN-1:0] imem_data,
  output wb_t              wb,
  output logic             halted,
  output logic [`XLEN-1:0] instret
);

  // stage one to register file
  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;

  // stage two
  decoded_t         decoded;
  logic [`XLEN-1:0] alu_result;
  logic             taken;
  logic [`XLEN-1:0] target;
  logic [`XLEN-1:0] link;
  redirect_t        redirect;

  // pc, fetch, decode and the stage register
  fetch_decode fetch_decode_0 (
    .clock     (clock),
    .rst_n     (rst_n),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .redirect  (redirect),
    .halted    (halted),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .decoded   (decoded)
  );

  // written from commit, read by decode
  register_file register_file_0 (
    .clock    (clock),
    .rst_n    (rst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  // ------------------------------
  // execute, alu and branch in parallel
  // ------------------------------

  alu alu_0 (
    .decoded (decoded),
    .result  (alu_result)
  );

  branch_unit branch_unit_0 (
    .decoded (decoded),
    .taken   (taken),
    .target  (target),
    .link    (link)
  );

  commit_unit commit_unit_0 (
    .clock      (clock),
    .rst_n      (rst_n),
    .decoded    (decoded),
    .alu_result (alu_result),
    .taken      (taken),
    .target     (target),
    .link       (link),
    .wb         (wb),
    .redirect   (redirect),
    .halted     (halted),
    .instret    (instret)
  );

endmodule

`default_nettype wire

// File: sim/rv_core_sva.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defines.svh"

module rv_core_sva import rv_pkg::*; (
  input logic             clock,
  input logic             rst_n,
  input logic [`XLEN-1:0] imem_addr,
  input wb_t              wb,
  input logic             halted
);

  // x0 writes stay inside the core
  wb_not_x0: assert property (@(posedge clock) disable iff (!rst_n)
    wb.valid |-> (wb.rd != '0))
    else $error("writeback names x0");

  // halt is sticky
  halt_sticky: assert property (@(posedge clock) disable iff (!rst_n)
    halted |=> halted)
    else $error("halted dropped");

  // nothing commits once halted
  halt_quiet: assert property (@(posedge clock) disable iff (!rst_n)
    halted |-> !wb.valid)
    else $error("commit after halt");

  // fetch on word boundaries only
  fetch_aligned: assert property (@(posedge clock) disable iff (!rst_n)
    imem_addr[1:0] == 2'b00)
    else $error("misaligned fetch address");

endmodule

bind rv_core rv_core_sva sva0 (
  .clock     (clock),
  .rst_n     (rst_n),
  .imem_addr (imem_addr),
  .wb        (wb),
  .halted    (halted)
);

`default_nettype wire

// File: sim/rv_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defines.svh"

module rv_core_tb import rv_pkg::*; ();

  localparam int mem_words      = 256;
  localparam int timeout_cycles = 2000;
  localparam int model_steps    = 1000;

  // rv32i major opcodes
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_system = 7'b1110011;

  logic             clock;
  logic             rst_n;
  logic [`XLEN-1:0] imem_addr;
  logic [`XLEN-1:0] imem_data;
  wb_t              wb;
  logic             halted;
  logic [`XLEN-1:0] instret;

  // program image and generator state
  logic [`XLEN-1:0] prog [0:mem_words-1];
  int               prog_len;
  logic [31:0]      rng_state;

  // expected commits in program order
  wb_t              exp_wb [$];
  int               exp_count;

  initial clock = 1'b0;
  always #50 clock = ~clock;

  rv_core dut0 (
    .clock     (clock),
    .rst_n     (rst_n),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .wb        (wb),
    .halted    (halted),
    .instret   (instret)
  );

  // combinational instruction port
  assign imem_data = prog[imem_addr[9:2]];

  // ------------------------------
  // random numbers and encoders
  // ------------------------------

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  // byte offset whose bit 0 the format drops
  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
  endfunction

  // random op or op_imm on x0..x15
  function automatic logic [31:0] random_alu();
    logic [31:0] r;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic        alt;
    logic [31:0] word;
    r   = next_rand();
    f3  = r[2:0];
    alt = r[3] && ((f3 == 3'b000) || (f3 == 3'b101));
    imm = r[31:20];
    // immediate shifts carry only shamt and bit 10 for srai
    if (f3 == 3'b001) begin
      imm = {7'b0, r[24:20]};
    end else if (f3 == 3'b101) begin
      imm = {1'b0, r[3], 5'b0, r[24:20]};
    end
    if (r[16]) begin
      word = r_type({1'b0, alt, 5'b0}, {1'b0, r[15:12]}, {1'b0, r[11:8]}, f3,
                    {1'b0, r[7:4]});
    end else begin
      word = i_type(imm, {1'b0, r[11:8]}, f3, {1'b0, r[7:4]}, opc_op_imm);
    end
    return word;
  endfunction

  task automatic place(input logic [31:0] word);
    prog[prog_len] = word;
    prog_len++;
  endtask

  // ------------------------------
  // program
  // ------------------------------

  task automatic build_program();
    logic [31:0] r;
    logic [31:0] bump;
    rng_state = 32'h9ebb;
    prog_len  = 0;
    // fill with lui x1 tagged by its word index
    for (int i = 0; i < mem_words; i++) begin
      prog[i] = u_type(i[19:0] ^ 20'h5a5a5, 5'd1, opc_lui);
    end
    // bump of x9 by one is the word a taken branch skips
    bump = i_type(12'd1, 5'd9, 3'b000, 5'd9, opc_op_imm);
    // give x1..x15 defined values
    for (int k = 1; k < 16; k++) begin
      r = next_rand();
      place(u_type(r[31:12], k[4:0], opc_lui));
      place(i_type(r[11:0], k[4:0], 3'b000, k[4:0], opc_op_imm));
    end
    for (int k = 0; k < 24; k++) begin
      place(random_alu());
    end
    // sra vs srl and slt vs sltu on a negative value read right after its write
    place(i_type(12'hffb, 5'd0, 3'b000, 5'd3, opc_op_imm));
    place(i_type(12'h401, 5'd3, 3'b101, 5'd4, opc_op_imm));
    place(i_type(12'h001, 5'd3, 3'b101, 5'd5, opc_op_imm));
    place(r_type(7'b0, 5'd0, 5'd3, 3'b010, 5'd6));
    place(r_type(7'b0, 5'd0, 5'd3, 3'b011, 5'd7));
    for (int k = 0; k < 4; k++) begin
      r = next_rand();
      place(u_type(r[31:12], {1'b0, r[7:4]}, opc_lui));
      r = next_rand();
      place(u_type(r[31:12], {1'b0, r[7:4]}, opc_auipc));
    end
    // writes to x0 never show on wb
    place(u_type(20'habcde, 5'd0, opc_lui));
    place(i_type(12'h123, 5'd1, 3'b000, 5'd0, opc_op_imm));
    // every condition on equal operands and then on random ones with offset 8
    for (int c = 0; c < 8; c++) begin
      if ((c != 2) && (c != 3)) begin
        r = next_rand();
        place(b_type(13'd8, {1'b0, r[7:4]}, {1'b0, r[7:4]}, c[2:0]));
        place(bump);
        place(b_type(13'd8, {1'b0, r[15:12]}, {1'b0, r[11:8]}, c[2:0]));
        place(bump);
        place(random_alu());
      end
    end
    // jal over one word
    place(j_type(21'd8, 5'd10));
    place(bump);
    // jalr with an odd sum lands on the word at auipc + 12
    place(u_type(20'd0, 5'd11, opc_auipc));
    place(i_type(12'd13, 5'd11, 3'b000, 5'd12, opc_jalr));
    place(bump);
    // landing word exposes the fetch pc
    place(u_type(20'd0, 5'd13, opc_auipc));
    for (int k = 0; k < 8; k++) begin
      place(random_alu());
    end
    // ecall
    place(32'h0000_0073);
  endtask

  // ------------------------------
  // reference model
  // ------------------------------

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [31:0] res;
    case (f3)
      3'b000: res = alt ? (a - b) : (a + b);
      3'b001: res = a << b[4:0];
      3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: res = (a < b) ? 32'd1 : 32'd0;
      3'b100: res = a ^ b;
      3'b101: begin
        if (alt) begin
          res = $signed(a) >>> b[4:0];
        end else begin
          res = a >> b[4:0];
        end
      end
      3'b110: res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    logic t;
    case (f3)
      3'b000:  t = (a == b);
      3'b001:  t = (a != b);
      3'b100:  t = ($signed(a) < $signed(b));
      3'b101:  t = ($signed(a) >= $signed(b));
      3'b110:  t = (a < b);
      default: t = (a >= b);
    endcase
    return t;
  endfunction

  // runs the program to ecall and fills exp_wb and exp_count
  function automatic void run_model();
    logic [31:0] regs [0:31];
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] res;
    logic        writes;
    wb_t         commit;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    pc        = 32'd0;
    exp_count = 0;
    while (exp_count < model_steps) begin
      ins     = prog[pc[9:2]];
      a       = regs[ins[19:15]];
      b       = regs[ins[24:20]];
      imm_i   = {{20{ins[31]}}, ins[31:20]};
      next_pc = pc + 32'd4;
      res     = '0;
      writes  = 1'b1;
      exp_count++;
      case (ins[6:0])
        opc_lui:   res = {ins[31:12], 12'b0};
        opc_auipc: res = pc + {ins[31:12], 12'b0};
        opc_jal: begin
          res     = pc + 32'd4;
          next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        opc_jalr: begin
          res     = pc + 32'd4;
          next_pc = (a + imm_i) & ~32'd1;
        end
        opc_branch: begin
          writes = 1'b0;
          if (branch_ref(ins[14:12], a, b)) begin
            next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
          end
        end
        opc_op_imm: res = alu_ref(ins[14:12], (ins[14:12] == 3'b101) && ins[30], a, imm_i);
        opc_op:     res = alu_ref(ins[14:12], ins[30], a, b);
        opc_system: return;
        default:    writes = 1'b0;
      endcase
      if (writes && (ins[11:7] != 5'd0)) begin
        regs[ins[11:7]] = res;
        commit.valid    = 1'b1;
        commit.rd       = ins[11:7];
        commit.data     = res;
        exp_wb.push_back(commit);
      end
      pc = next_pc;
    end
  endfunction

  // ------------------------------
  // checking
  // ------------------------------

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "testbench stopped on the first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      stop_with_failure($sformatf("mismatch at %0t ns: %s got %h, expected %h",
                                  $time, what, got, want));
    end
  endtask

  // wb settles after the rising edge and is sampled on the falling one
  always @(negedge clock) begin
    wb_t expected;
    if (rst_n && (wb.valid !== 1'b0)) begin
      if (exp_wb.size() == 0) begin
        stop_with_failure($sformatf("commit to x%0d after the last expected commit", wb.rd));
      end else begin
        expected = exp_wb.pop_front();
        check_value("commit rd", 32'(wb.rd), 32'(expected.rd));
        check_value("commit data", wb.data, expected.data);
      end
    end
  end

  initial begin
    int cycles;
    rst_n = 1'b0;
    build_program();
    run_model();
    repeat (4) @(posedge clock);
    rst_n <= 1'b1;
    cycles = 0;
    while (halted !== 1'b1) begin
      if (cycles == timeout_cycles) begin
        stop_with_failure("timeout: the core never raised halted");
      end
      @(negedge clock);
      cycles++;
    end
    // quiet period where no commit may follow
    repeat (4) @(negedge clock);
    // queue only moves on falling edges
    @(posedge clock);
    check_value("instret", instret, 32'(exp_count));
    if (exp_wb.size() != 0) begin
      stop_with_failure($sformatf("%0d expected commits never appeared", exp_wb.size()));
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+design
design/rv_pkg.sv
design/register_file.sv
design/fetch_decode.sv
design/alu.sv
design/branch_unit.sv
design/commit_unit.sv
design/rv_core.sv
sim/rv_core_sva.sv
sim/rv_core_tb.sv

// File: Makefile
SIM      := verilator
TOP      := rv_core_tb
FILELIST := files.f
BUILD    := obj_dir
FLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD)

SOURCES  := $(wildcard design/*.sv design/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
